//--- tb.f
verilog/timer_pkg.sv
verilog/axil_write_decode.sv
verilog/timer_regs.sv
verilog/countdown_engine.sv
verilog/axil_read_result.sv
verilog/axil_timer_top.sv
testbench/tb_axil_timer.sv

//--- testbench/tb_axil_timer.sv
module tb_axil_timer;
    timeunit 1ns;
    timeprecision 1ps;

    // Longest test sequence is well under 800 cycles
    localparam int MAX_CYCLES = 3000;

    logic              clk;
    logic              rst_n;
    timer_pkg::addr_t  s_axi_awaddr;
    logic              s_axi_awvalid;
    logic              s_axi_awready;
    timer_pkg::data_t  s_axi_wdata;
    timer_pkg::strb_t  s_axi_wstrb;
    logic              s_axi_wvalid;
    logic              s_axi_wready;
    timer_pkg::resp_t  s_axi_bresp;
    logic              s_axi_bvalid;
    logic              s_axi_bready;
    timer_pkg::addr_t  s_axi_araddr;
    logic              s_axi_arvalid;
    logic              s_axi_arready;
    timer_pkg::data_t  s_axi_rdata;
    timer_pkg::resp_t  s_axi_rresp;
    logic              s_axi_rvalid;
    logic              s_axi_rready;
    logic              irq;

    int                errors;
    int                checks;
    int                cycles;
    integer            seed;
    string             test_name;
    timer_pkg::data_t  ctrl_model;
    timer_pkg::data_t  cfg_model;
    timer_pkg::data_t  rnd_data;
    timer_pkg::strb_t  rnd_strb;
    timer_pkg::data_t  rd_data;
    timer_pkg::resp_t  rd_resp;

    axil_timer_top u_axil_timer_top (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    a_bresp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
        else begin
            errors++;
            $display("Write response dropped or changed while bready was low");
        end

    a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
            && $stable(s_axi_rresp))
        else begin
            errors++;
            $display("Read response dropped or changed while rready was low");
        end

    // Ready may only rise once the master offers a beat
    a_ready_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (!s_axi_awready || s_axi_awvalid) && (!s_axi_wready || s_axi_wvalid)
            && (!s_axi_arready || s_axi_arvalid))
        else begin
            errors++;
            $display("A ready signal was high without its valid");
        end

    function automatic timer_pkg::data_t apply_strobes(input timer_pkg::data_t old_val,
                                                       input timer_pkg::data_t new_val,
                                                       input timer_pkg::strb_t strb);
        timer_pkg::data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic int rand_stall();
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic check_value(input string what, input timer_pkg::data_t exp,
                               input timer_pkg::data_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_at_most(input string what, input timer_pkg::data_t limit,
                                 input timer_pkg::data_t act);
        checks++;
        assert (act <= limit) else begin
            errors++;
            $display("ERR %s %s: expected at most %0d actual %0d", test_name, what, limit, act);
        end
    endtask

    task automatic axil_write(input timer_pkg::addr_t addr, input timer_pkg::data_t data,
                              input timer_pkg::strb_t strb, input int stall,
                              output timer_pkg::resp_t resp);
        @(posedge clk);
        #1;
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_wvalid  = 1'b1;
        @(posedge clk);
        while (!s_axi_awready) @(posedge clk);
        #1;
        s_axi_awvalid = 1'b0;
        @(posedge clk);
        while (!s_axi_wready) @(posedge clk);
        #1;
        s_axi_wvalid = 1'b0;
        repeat (stall) begin
            @(posedge clk);
            #1;
        end
        s_axi_bready = 1'b1;
        @(posedge clk);
        while (!s_axi_bvalid) @(posedge clk);
        resp = s_axi_bresp;
        #1;
        s_axi_bready = 1'b0;
    endtask

    task automatic axil_read(input timer_pkg::addr_t addr, input int stall,
                             output timer_pkg::data_t data, output timer_pkg::resp_t resp);
        @(posedge clk);
        #1;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        @(posedge clk);
        while (!s_axi_arready) @(posedge clk);
        #1;
        s_axi_arvalid = 1'b0;
        repeat (stall) begin
            @(posedge clk);
            #1;
        end
        s_axi_rready = 1'b1;
        @(posedge clk);
        while (!s_axi_rvalid) @(posedge clk);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        #1;
        s_axi_rready = 1'b0;
    endtask

    // Write, check the response and track control and config
    task automatic write_check(input timer_pkg::addr_t addr, input timer_pkg::data_t data,
                               input timer_pkg::strb_t strb, input timer_pkg::resp_t exp_resp);
        timer_pkg::resp_t resp;
        axil_write(addr, data, strb, rand_stall(), resp);
        check_value($sformatf("bresp at %h", addr[7:0]), exp_resp, resp);
        if (addr[7:0] == timer_pkg::OFS_CONTROL) begin
            ctrl_model = apply_strobes(ctrl_model, data, strb);
            ctrl_model[timer_pkg::CTRL_START_BIT] = 1'b0;
        end else if (addr[7:0] == timer_pkg::OFS_CONFIG) begin
            cfg_model = apply_strobes(cfg_model, data, strb);
        end
    endtask

    task automatic read_check(input timer_pkg::addr_t addr, input timer_pkg::data_t exp_data,
                              input timer_pkg::resp_t exp_resp);
        timer_pkg::data_t data;
        timer_pkg::resp_t resp;
        axil_read(addr, rand_stall(), data, resp);
        check_value($sformatf("rdata at %h", addr[7:0]), exp_data, data);
        check_value($sformatf("rresp at %h", addr[7:0]), exp_resp, resp);
    endtask

    task automatic read_value(input timer_pkg::addr_t addr, output timer_pkg::data_t data);
        timer_pkg::resp_t resp;
        axil_read(addr, rand_stall(), data, resp);
        check_value($sformatf("rresp at %h", addr[7:0]), timer_pkg::RESP_OKAY, resp);
    endtask

    // Done lands one cycle after busy falls, so one idle snapshot is allowed
    task automatic poll_until_done(input timer_pkg::data_t limit);
        timer_pkg::data_t stat;
        timer_pkg::data_t cnt;
        logic             idle_once;
        idle_once = 1'b0;
        stat = '0;
        while (!stat[timer_pkg::STAT_DONE_BIT]) begin
            read_value(timer_pkg::OFS_STATUS, stat);
            if (!stat[timer_pkg::STAT_DONE_BIT]) begin
                if (!stat[timer_pkg::STAT_BUSY_BIT] && idle_once) begin
                    check_value("busy before done", 32'd1, 32'd0);
                end
                idle_once = !stat[timer_pkg::STAT_BUSY_BIT];
                read_value(timer_pkg::OFS_COUNT, cnt);
                check_at_most("count while busy", limit, cnt);
            end
        end
        read_check(timer_pkg::OFS_STATUS, 32'h2, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_COUNT, 32'd0, timer_pkg::RESP_OKAY);
    endtask

    task automatic run_countdown(input timer_pkg::data_t load);
        write_check(timer_pkg::OFS_STATUS, 32'h2, 4'hF, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONFIG, load, 4'hF, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONTROL, 32'h3, 4'h1, timer_pkg::RESP_OKAY);
        poll_until_done(load);
    endtask

    initial begin
        seed          = 27626;
        clk           = 1'b0;
        rst_n         = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        ctrl_model    = '0;
        cfg_model     = '0;
        test_name     = "reset";
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        check_value("ready, valid and irq low", 32'd0, {s_axi_awready, s_axi_wready,
                    s_axi_bvalid, s_axi_arready, s_axi_rvalid, irq});

        test_name = "readback";
        write_check(timer_pkg::OFS_CONFIG, 32'hFFFF_FFFF, 4'hF, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_CONFIG, cfg_model, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONFIG, 32'h1234_5678, 4'b0101, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_CONFIG, cfg_model, timer_pkg::RESP_OKAY);
        rnd_data = $random(seed);
        rnd_strb = timer_pkg::strb_t'($random(seed));
        write_check(timer_pkg::OFS_CONFIG, rnd_data, rnd_strb, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_CONFIG, cfg_model, timer_pkg::RESP_OKAY);
        // Zero load keeps the start below from running the engine for long
        write_check(timer_pkg::OFS_CONFIG, 32'h0, 4'hF, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONTROL, 32'hA5A5_A5A4, 4'hF, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_CONTROL, ctrl_model, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONTROL, 32'h0000_0003, 4'b0001, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_CONTROL, ctrl_model, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONTROL, 32'h0, 4'b1110, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_CONTROL, ctrl_model, timer_pkg::RESP_OKAY);

        test_name = "countdown";
        repeat (3) begin
            run_countdown($unsigned($random(seed)) % 41);
        end

        test_name = "done_irq";
        write_check(timer_pkg::OFS_STATUS, 32'h2, 4'hF, timer_pkg::RESP_OKAY);
        check_value("irq after clear", 32'd0, irq);
        write_check(timer_pkg::OFS_CONFIG, 32'd30, 4'hF, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONTROL, 32'h3, 4'h1, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONFIG, 32'd300, 4'hF, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONTROL, 32'h3, 4'h1, timer_pkg::RESP_OKAY);
        poll_until_done(32'd30);
        check_value("irq with done and enable", 32'd1, irq);
        write_check(timer_pkg::OFS_CONTROL, 32'h0, 4'h1, timer_pkg::RESP_OKAY);
        check_value("irq with enable off", 32'd0, irq);
        read_check(timer_pkg::OFS_STATUS, 32'h2, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_CONTROL, 32'h2, 4'h1, timer_pkg::RESP_OKAY);
        check_value("irq with enable back on", 32'd1, irq);
        write_check(timer_pkg::OFS_STATUS, 32'h2, 4'hF, timer_pkg::RESP_OKAY);
        check_value("irq after done clear", 32'd0, irq);
        read_check(timer_pkg::OFS_STATUS, 32'h0, timer_pkg::RESP_OKAY);

        test_name = "unmapped";
        write_check(32'h10, 32'hFFFF_FFFF, 4'hF, timer_pkg::RESP_SLVERR);
        write_check(32'h40, 32'hFFFF_FFFF, 4'hF, timer_pkg::RESP_SLVERR);
        read_check(32'h10, 32'h0, timer_pkg::RESP_SLVERR);
        read_check(32'h40, 32'h0, timer_pkg::RESP_SLVERR);
        read_check(timer_pkg::OFS_CONTROL, ctrl_model, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_CONFIG, cfg_model, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_STATUS, 32'h0, timer_pkg::RESP_OKAY);
        write_check(timer_pkg::OFS_COUNT, 32'h0000_1234, 4'hF, timer_pkg::RESP_OKAY);
        read_check(timer_pkg::OFS_COUNT, 32'h0, timer_pkg::RESP_OKAY);
        read_check(32'h104, cfg_model, timer_pkg::RESP_OKAY);

        test_name = "back_pressure";
        axil_write(timer_pkg::OFS_CONFIG, 32'h0BAD_F00D, 4'hF, 6, rd_resp);
        check_value("bresp after stall", timer_pkg::RESP_OKAY, rd_resp);
        cfg_model = 32'h0BAD_F00D;
        axil_read(timer_pkg::OFS_CONFIG, 6, rd_data, rd_resp);
        check_value("rdata after stall", cfg_model, rd_data);
        axil_read(32'h10, 5, rd_data, rd_resp);
        check_value("rresp after stall", timer_pkg::RESP_SLVERR, rd_resp);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/axil_timer_top.sv
module axil_timer_top (
    input  logic              clk,
    input  logic              rst_n,
    input  timer_pkg::addr_t  s_axi_awaddr,
    input  logic              s_axi_awvalid,
    output logic              s_axi_awready,
    input  timer_pkg::data_t  s_axi_wdata,
    input  timer_pkg::strb_t  s_axi_wstrb,
    input  logic              s_axi_wvalid,
    output logic              s_axi_wready,
    output timer_pkg::resp_t  s_axi_bresp,
    output logic              s_axi_bvalid,
    input  logic              s_axi_bready,
    input  timer_pkg::addr_t  s_axi_araddr,
    input  logic              s_axi_arvalid,
    output logic              s_axi_arready,
    output timer_pkg::data_t  s_axi_rdata,
    output timer_pkg::resp_t  s_axi_rresp,
    output logic              s_axi_rvalid,
    input  logic              s_axi_rready,
    output logic              irq
);

    timer_pkg::wr_req_t      wr_req;
    timer_pkg::engine_ctl_t  engine_ctl;
    timer_pkg::reg_view_t    view;
    timer_pkg::data_t        count;
    logic                    busy;
    logic                    done_pulse;

    axil_write_decode u_write (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (s_axi_awaddr),
        .awvalid (s_axi_awvalid),
        .awready (s_axi_awready),
        .wdata   (s_axi_wdata),
        .wstrb   (s_axi_wstrb),
        .wvalid  (s_axi_wvalid),
        .wready  (s_axi_wready),
        .bresp   (s_axi_bresp),
        .bvalid  (s_axi_bvalid),
        .bready  (s_axi_bready),
        .wr_req  (wr_req)
    );

    timer_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_req     (wr_req),
        .busy       (busy),
        .count      (count),
        .done_pulse (done_pulse),
        .engine_ctl (engine_ctl),
        .view       (view),
        .irq        (irq)
    );

    countdown_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .engine_ctl (engine_ctl),
        .busy       (busy),
        .count      (count),
        .done_pulse (done_pulse)
    );

    axil_read_result u_read (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (s_axi_araddr),
        .arvalid (s_axi_arvalid),
        .arready (s_axi_arready),
        .rdata   (s_axi_rdata),
        .rresp   (s_axi_rresp),
        .rvalid  (s_axi_rvalid),
        .rready  (s_axi_rready),
        .view    (view)
    );

endmodule

//--- verilog/axil_read_result.sv
module axil_read_result (
    input  logic                  clk,
    input  logic                  rst_n,
    input  timer_pkg::addr_t      araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output timer_pkg::data_t      rdata,
    output timer_pkg::resp_t      rresp,
    output logic                  rvalid,
    input  logic                  rready,
    input  timer_pkg::reg_view_t  view
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        RESP
    } state_t;

    state_t              state;
    state_t              state_next;
    timer_pkg::offset_t  ar_offset;
    timer_pkg::data_t    sel_data;
    timer_pkg::resp_t    sel_resp;

    assign ar_offset = araddr[7:0];

    always_comb begin
        sel_data = '0;
        sel_resp = timer_pkg::RESP_OKAY;
        case (ar_offset)
            timer_pkg::OFS_CONTROL: sel_data = view.control;
            timer_pkg::OFS_CONFIG:  sel_data = view.cfg;
            timer_pkg::OFS_STATUS:  sel_data = view.status;
            timer_pkg::OFS_COUNT:   sel_data = view.count;
            default:                sel_resp = timer_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (arvalid) state_next = ADDR;
            ADDR: state_next = RESP;
            RESP: if (rready) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign arready = (state == ADDR);
    assign rvalid  = (state == RESP);

    // Snapshot taken on the AR beat, held through back-pressure
    always_ff @(posedge clk) begin
        if (arready) begin
            rdata <= sel_data;
            rresp <= sel_resp;
        end
    end

    a_rdata_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

//--- verilog/countdown_engine.sv
module countdown_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  timer_pkg::engine_ctl_t  engine_ctl,
    output logic                    busy,
    output timer_pkg::data_t        count,
    output logic                    done_pulse
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            count      <= '0;
            done_pulse <= 1'b0;
        end else begin
            done_pulse <= 1'b0;
            if (busy) begin
                // Start requests while running are dropped
                count <= count - 1'b1;
                if (count == 32'd1) begin
                    busy       <= 1'b0;
                    done_pulse <= 1'b1;
                end
            end else if (engine_ctl.start) begin
                count <= engine_ctl.load;
                if (engine_ctl.load == '0) begin
                    done_pulse <= 1'b1;
                end else begin
                    busy <= 1'b1;
                end
            end
        end
    end

    a_done_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        done_pulse |-> !busy
    );

    a_busy_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy |-> (count != '0)
    );

endmodule

//--- verilog/timer_regs.sv
module timer_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  timer_pkg::wr_req_t      wr_req,
    input  logic                    busy,
    input  timer_pkg::data_t        count,
    input  logic                    done_pulse,
    output timer_pkg::engine_ctl_t  engine_ctl,
    output timer_pkg::reg_view_t    view,
    output logic                    irq
);

    timer_pkg::data_t  control_r;
    timer_pkg::data_t  control_next;
    timer_pkg::data_t  cfg_r;
    timer_pkg::data_t  status_w;
    logic              done_r;
    logic              wr_control;
    logic              wr_config;
    logic              done_clear;

    function automatic timer_pkg::data_t merge_bytes(
        input timer_pkg::data_t old_val,
        input timer_pkg::data_t new_val,
        input timer_pkg::strb_t strb
    );
        timer_pkg::data_t result;
        result = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return result;
    endfunction

    assign wr_control = wr_req.valid && wr_req.sel[timer_pkg::SEL_CONTROL];
    assign wr_config  = wr_req.valid && wr_req.sel[timer_pkg::SEL_CONFIG];

    // W1C on done sits in the low byte
    assign done_clear = wr_req.valid && wr_req.sel[timer_pkg::SEL_STATUS]
                        && wr_req.strb[0] && wr_req.data[timer_pkg::STAT_DONE_BIT];

    always_comb begin
        control_next = control_r;
        if (wr_control) begin
            control_next = merge_bytes(control_r, wr_req.data, wr_req.strb);
        end
        // Start lives for one cycle only
        if (control_r[timer_pkg::CTRL_START_BIT]) begin
            control_next[timer_pkg::CTRL_START_BIT] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            control_r <= '0;
            cfg_r     <= '0;
            done_r    <= 1'b0;
        end else begin
            control_r <= control_next;
            if (wr_config) begin
                cfg_r <= merge_bytes(cfg_r, wr_req.data, wr_req.strb);
            end
            if (done_pulse) begin
                done_r <= 1'b1;
            end else if (done_clear) begin
                done_r <= 1'b0;
            end
        end
    end

    always_comb begin
        status_w = '0;
        status_w[timer_pkg::STAT_BUSY_BIT] = busy;
        status_w[timer_pkg::STAT_DONE_BIT] = done_r;
    end

    assign engine_ctl.start = control_r[timer_pkg::CTRL_START_BIT];
    assign engine_ctl.load  = cfg_r;

    assign view.control = control_r;
    assign view.cfg     = cfg_r;
    assign view.status  = status_w;
    assign view.count   = count;

    assign irq = done_r && control_r[timer_pkg::CTRL_IRQ_EN_BIT];

    a_start_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        control_r[timer_pkg::CTRL_START_BIT] |=> !control_r[timer_pkg::CTRL_START_BIT]
    );

endmodule

//--- verilog/axil_write_decode.sv
module axil_write_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  timer_pkg::addr_t    awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  timer_pkg::data_t    wdata,
    input  timer_pkg::strb_t    wstrb,
    input  logic                wvalid,
    output logic                wready,
    output timer_pkg::resp_t    bresp,
    output logic                bvalid,
    input  logic                bready,
    output timer_pkg::wr_req_t  wr_req
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } state_t;

    state_t               state;
    state_t               state_next;
    timer_pkg::offset_t   aw_offset;
    timer_pkg::reg_sel_t  aw_sel;
    timer_pkg::reg_sel_t  sel_r;
    logic                 mapped;
    logic                 w_beat;

    // Upper address bits are ignored
    assign aw_offset = awaddr[7:0];

    always_comb begin
        aw_sel = '0;
        case (aw_offset)
            timer_pkg::OFS_CONTROL: aw_sel[timer_pkg::SEL_CONTROL] = 1'b1;
            timer_pkg::OFS_CONFIG:  aw_sel[timer_pkg::SEL_CONFIG]  = 1'b1;
            timer_pkg::OFS_STATUS:  aw_sel[timer_pkg::SEL_STATUS]  = 1'b1;
            timer_pkg::OFS_COUNT:   aw_sel[timer_pkg::SEL_COUNT]   = 1'b1;
            default:                aw_sel = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (awvalid) state_next = ADDR;
            ADDR: state_next = DATA;
            DATA: if (wvalid) state_next = RESP;
            RESP: if (bready) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign awready = (state == ADDR);
    assign wready  = (state == DATA);
    assign bvalid  = (state == RESP);
    assign w_beat  = wready && wvalid;
    assign mapped  = |sel_r;

    always_ff @(posedge clk) begin
        if (awready) begin
            sel_r <= aw_sel;
        end
        if (w_beat) begin
            bresp <= mapped ? timer_pkg::RESP_OKAY : timer_pkg::RESP_SLVERR;
        end
    end

    // Unmapped offsets never reach the register bank
    always_comb begin
        wr_req.valid = w_beat && mapped;
        wr_req.sel   = sel_r;
        wr_req.data  = wdata;
        wr_req.strb  = wstrb;
    end

    // A write pulse belongs to the W beat and is answered on the next cycle
    a_wr_req_in_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_req.valid |-> (state == DATA) && wvalid ##1 bvalid
    );

endmodule

//--- verilog/timer_pkg.sv
package timer_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [7:0]  offset_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Register map
    localparam offset_t OFS_CONTROL = 8'h00;
    localparam offset_t OFS_CONFIG  = 8'h04;
    localparam offset_t OFS_STATUS  = 8'h08;
    localparam offset_t OFS_COUNT   = 8'h0C;

    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_IRQ_EN_BIT = 1;
    localparam int STAT_BUSY_BIT   = 0;
    localparam int STAT_DONE_BIT   = 1;

    // Bit positions inside the one-hot select
    localparam int SEL_CONTROL = 0;
    localparam int SEL_CONFIG  = 1;
    localparam int SEL_STATUS  = 2;
    localparam int SEL_COUNT   = 3;

    typedef logic [3:0] reg_sel_t;

    typedef struct packed {
        logic     valid;
        reg_sel_t sel;
        data_t    data;
        strb_t    strb;
    } wr_req_t;

    typedef struct packed {
        data_t control;
        data_t cfg;
        data_t status;
        data_t count;
    } reg_view_t;

    typedef struct packed {
        logic  start;
        data_t load;
    } engine_ctl_t;

endpackage
